/* logic/cpu_settings.svh */
/*
 * Core widths and fixed addresses, shared by RTL and testbench.
 * The address is exactly two data words wide.
 * Zero page is the lowest block of one data word's range.
 * Reset starts fetching at CPU_RESET_PC with no vector fetch.
 */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_DATA_W 16 // Data and instruction word

`define CPU_ADDR_W 32 // Word address, two data words

`define CPU_RESET_PC 32'h0000_0200 // First fetch after reset

`define CPU_ZERO_PAGE 16'h0000 // Upper word of every zp address

`endif

/* logic/cpu_isa_pkg.sv */
/*
 * Instruction-set types for the reduced 16-bit core.
 * One instruction word is read either as accumulator fields or as a branch.
 * Enum values follow the opcode bits they are decoded from.
 */
package cpu_isa_pkg;

	typedef enum logic [1:0] {ACC_A, ACC_B, ACC_C, ACC_D} acc_sel_t;

	typedef enum logic [2:0] {ORA, AND, EOR, ADC, PASS, LDA, CMP, SBC} alu_op_t; // Opcode 7:5

	typedef enum logic [2:0] {PL, MI, VC, VS, CC, CS, NE, EQ} cond_t; // Opcode 7:5 of a branch

	typedef enum logic [2:0] {
		IMPLIED, IMMEDIATE, ZERO_PAGE, ABSOLUTE, BRANCH, JUMP, ILLEGAL
	} addr_mode_t;

	typedef struct packed {
		logic [3:0] zero; // Must be clear
		acc_sel_t src_acc; // Bits 11:10
		acc_sel_t dst_acc; // Bits 9:8
		logic [7:0] opcode; // Group in 7:5, column in 4:0
	} acc_view_t;

	typedef struct packed {
		logic [7:0] zero; // No accumulator fields on branches
		cond_t cond;
		logic [4:0] column;
	} branch_view_t;

	typedef union packed {
		acc_view_t acc;
		branch_view_t br;
	} instr_t;

	localparam logic [4:0] COL_IMM = 5'h09; // 09, 29 .. E9
	localparam logic [4:0] COL_ZP = 5'h05;
	localparam logic [4:0] COL_ABS = 5'h0D;
	localparam logic [4:0] COL_BRANCH = 5'h10; // 10, 30 .. F0
	localparam logic [7:0] OPC_XFER = 8'h8B; // Txy, fields pick the pair
	localparam logic [15:0] WORD_JMP = 16'h004C;
	localparam logic [15:0] WORD_CLC = 16'h0018;
	localparam logic [15:0] WORD_SEC = 16'h0038;

endpackage

/* logic/cpu_ctrl_pkg.sv */
/*
 * Control types passed between sequencer, decoder and execute unit.
 * One instruction is in flight, so a single command covers all of it.
 */
package cpu_ctrl_pkg;

	typedef enum logic [2:0] {
		FETCH, // Opcode read
		DECODE, // Opcode word arrives
		OPER_LO, // First operand word arrives
		OPER_HI, // Second operand word arrives
		MEMORY, // Data access, store writes here
		BRANCH, // Take or skip
		EXECUTE // Execute unit strobe
	} seq_state_t;

	typedef struct packed {
		cpu_isa_pkg::alu_op_t alu_op;
		cpu_isa_pkg::acc_sel_t src_acc;
		cpu_isa_pkg::acc_sel_t dst_acc;
		logic write_acc; // Result to dst
		logic set_nz;
		logic set_c;
		logic set_v;
		logic force_c; // CLC, SEC
		logic force_c_val;
	} exec_cmd_t;

endpackage

/* logic/exec_if.sv */
/*
 * Link between the sequencer and the execute unit.
 * The execute unit acts only on exec_strobe in a cycle with rdy high.
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

interface exec_if;
	logic [`CPU_DATA_W-1:0] operand; // Immediate or memory word
	logic exec_strobe; // One cycle, EXECUTE state
	cpu_ctrl_pkg::exec_cmd_t cmd;
	cpu_isa_pkg::cond_t cond; // Held branch condition
	logic [`CPU_DATA_W-1:0] store_data; // Source accumulator
	logic cond_true;

	modport seq (output operand, exec_strobe, cmd, cond,
		input store_data, cond_true);

	modport exe (input operand, exec_strobe, cmd, cond,
		output store_data, cond_true);
endinterface

/* logic/instr_decoder.sv */
/*
 * Combinational decode of one instruction word.
 * Only the accumulator-field columns, branches, JMP abs, CLC and SEC exist.
 * Every other word is ILLEGAL and runs as a one-word no-op.
 */
`timescale 1ns/1ps

module instr_decoder (
	input  cpu_isa_pkg::instr_t ir,
	output cpu_isa_pkg::addr_mode_t mode,
	output cpu_ctrl_pkg::exec_cmd_t cmd
);
	cpu_isa_pkg::alu_op_t group;

	assign group = cpu_isa_pkg::alu_op_t'(ir.acc.opcode[7:5]); // Same encoding as opcode

	always_comb begin
		mode = cpu_isa_pkg::ILLEGAL;
		cmd = '0; // No write, no flags
		cmd.alu_op = group;
		cmd.src_acc = ir.acc.src_acc;
		cmd.dst_acc = ir.acc.dst_acc;

		if (ir.br.zero == '0 && ir.br.column == cpu_isa_pkg::COL_BRANCH) begin
			mode = cpu_isa_pkg::BRANCH; // Condition read by sequencer
		end else if (ir == cpu_isa_pkg::WORD_JMP) begin
			mode = cpu_isa_pkg::JUMP;
		end else if (ir == cpu_isa_pkg::WORD_CLC || ir == cpu_isa_pkg::WORD_SEC) begin
			mode = cpu_isa_pkg::IMPLIED;
			cmd.force_c = 1'b1;
			cmd.force_c_val = ir.acc.opcode[5]; // Set only for 38
		end else if (ir.acc.zero == '0) begin
			if (ir.acc.opcode == cpu_isa_pkg::OPC_XFER) begin
				// Transfer src to dst, flags follow the moved value
				mode = cpu_isa_pkg::IMPLIED;
				cmd.alu_op = cpu_isa_pkg::PASS;
				cmd.write_acc = 1'b1;
				cmd.set_nz = 1'b1;
			end else begin
				case (ir.acc.opcode[4:0])
					cpu_isa_pkg::COL_IMM: mode = cpu_isa_pkg::IMMEDIATE;
					cpu_isa_pkg::COL_ZP: mode = cpu_isa_pkg::ZERO_PAGE;
					cpu_isa_pkg::COL_ABS: mode = cpu_isa_pkg::ABSOLUTE;
					default: mode = cpu_isa_pkg::ILLEGAL;
				endcase
				if (mode != cpu_isa_pkg::ILLEGAL) begin
					cmd.write_acc = !(group inside {cpu_isa_pkg::PASS, cpu_isa_pkg::CMP}); // STA, CMP
					cmd.set_nz = (group != cpu_isa_pkg::PASS); // STA leaves flags
					cmd.set_c = group inside {cpu_isa_pkg::ADC, cpu_isa_pkg::CMP,
						cpu_isa_pkg::SBC};
					cmd.set_v = group inside {cpu_isa_pkg::ADC, cpu_isa_pkg::SBC};
				end
			end
		end
	end
endmodule

/* logic/sequencer.sv */
/*
 * Bus sequencer: state machine, PC, address mux, IR and data-in hold.
 * A read word arrives on data_in one rdy-high cycle after its address.
 * With rdy low all state holds; a word arriving then is kept in the hold.
 * Absolute operands come low word first. Branch offsets are signed words
 * relative to the address after the offset word.
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module sequencer (
	input  logic clk,
	input  logic reset,
	input  logic rdy,
	output logic [`CPU_ADDR_W-1:0] addr,
	output logic we,
	output logic [`CPU_DATA_W-1:0] data_out,
	input  logic [`CPU_DATA_W-1:0] data_in,
	output cpu_isa_pkg::instr_t ir,
	input  cpu_isa_pkg::addr_mode_t mode,
	input  cpu_ctrl_pkg::exec_cmd_t cmd,
	exec_if.seq exe
);
	cpu_ctrl_pkg::seq_state_t state;
	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_DATA_W-1:0] oper_lo; // Imm, zp addr, abs low or offset
	logic [`CPU_DATA_W-1:0] oper_hi; // Abs high word
	cpu_isa_pkg::instr_t ir_q;
	logic [`CPU_DATA_W-1:0] din_hold;
	logic [`CPU_DATA_W-1:0] din;
	logic rdy_q; // rdy one cycle ago
	logic is_store;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rdy_q <= 1'b1;
		else
			rdy_q <= rdy;
	end

	always_ff @(posedge clk) begin
		if (!rdy && rdy_q)
			din_hold <= data_in; // Word that arrived as rdy fell
	end

	assign din = rdy_q ? data_in : din_hold;
	assign ir = (state == cpu_ctrl_pkg::DECODE) ? cpu_isa_pkg::instr_t'(din) : ir_q; // Decode early

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cpu_ctrl_pkg::FETCH;
			pc <= `CPU_RESET_PC;
		end else if (rdy) begin
			case (state)
				cpu_ctrl_pkg::FETCH: begin
					pc <= pc + 1'b1;
					state <= cpu_ctrl_pkg::DECODE;
				end
				cpu_ctrl_pkg::DECODE: begin
					if (mode == cpu_isa_pkg::IMPLIED)
						state <= cpu_ctrl_pkg::EXECUTE;
					else if (mode == cpu_isa_pkg::ILLEGAL)
						state <= cpu_ctrl_pkg::FETCH; // No-op
					else begin
						pc <= pc + 1'b1; // First operand word
						state <= cpu_ctrl_pkg::OPER_LO;
					end
				end
				cpu_ctrl_pkg::OPER_LO: begin
					case (mode)
						cpu_isa_pkg::IMMEDIATE: state <= cpu_ctrl_pkg::EXECUTE;
						cpu_isa_pkg::ZERO_PAGE: state <= cpu_ctrl_pkg::MEMORY;
						cpu_isa_pkg::BRANCH: state <= cpu_ctrl_pkg::BRANCH;
						default: begin
							pc <= pc + 1'b1; // ABS and JMP high word
							state <= cpu_ctrl_pkg::OPER_HI;
						end
					endcase
				end
				cpu_ctrl_pkg::OPER_HI: begin
					if (mode == cpu_isa_pkg::JUMP) begin
						pc <= {din, oper_lo};
						state <= cpu_ctrl_pkg::FETCH;
					end else
						state <= cpu_ctrl_pkg::MEMORY;
				end
				cpu_ctrl_pkg::MEMORY: state <= cpu_ctrl_pkg::EXECUTE;
				cpu_ctrl_pkg::BRANCH: begin
					if (exe.cond_true) // Full-width add, sign extended offset
						pc <= pc + {{(`CPU_ADDR_W-`CPU_DATA_W){oper_lo[`CPU_DATA_W-1]}}, oper_lo};
					state <= cpu_ctrl_pkg::FETCH;
				end
				default: state <= cpu_ctrl_pkg::FETCH; // EXECUTE
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rdy) begin
			if (state == cpu_ctrl_pkg::DECODE)
				ir_q <= din;
			if (state == cpu_ctrl_pkg::OPER_LO)
				oper_lo <= din;
			if (state == cpu_ctrl_pkg::OPER_HI)
				oper_hi <= din;
		end
	end

	always_comb begin
		if (state == cpu_ctrl_pkg::MEMORY && mode == cpu_isa_pkg::ZERO_PAGE)
			addr = {`CPU_ZERO_PAGE, oper_lo};
		else if (state == cpu_ctrl_pkg::MEMORY)
			addr = {oper_hi, oper_lo}; // Absolute
		else
			addr = pc;
	end

	assign is_store = (cmd.alu_op == cpu_isa_pkg::PASS) && !cmd.write_acc; // STA
	assign we = (state == cpu_ctrl_pkg::MEMORY) && is_store;
	assign data_out = exe.store_data;

	assign exe.operand = (mode == cpu_isa_pkg::IMMEDIATE) ? oper_lo : din; // Else memory word
	assign exe.exec_strobe = (state == cpu_ctrl_pkg::EXECUTE);
	assign exe.cmd = cmd;
	assign exe.cond = ir_q.br.cond;
endmodule

/* logic/execute_unit.sv */
/*
 * Accumulators A to D, ALU, N Z C V flags and branch condition.
 * State changes only on exec_strobe with rdy high.
 * ADC adds with carry; SBC subtracts with borrow as inverted carry.
 * CMP subtracts with carry in forced high, so equal values give Z and C set.
 * V is changed only by ADC and SBC.
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_unit (
	input  logic clk,
	input  logic reset,
	input  logic rdy,
	exec_if.exe exe
);
	localparam int MSB = `CPU_DATA_W - 1;

	logic [3:0][`CPU_DATA_W-1:0] acc; // Indexed by acc_sel_t
	logic n;
	logic z;
	logic c;
	logic v;
	logic [`CPU_DATA_W-1:0] src;
	logic [`CPU_DATA_W-1:0] b_in;
	logic [`CPU_DATA_W-1:0] result;
	logic [`CPU_DATA_W:0] sum; // Top bit is carry out
	logic subtract;
	logic carry_in;
	logic overflow;

	assign src = acc[exe.cmd.src_acc];
	assign subtract = exe.cmd.alu_op inside {cpu_isa_pkg::CMP, cpu_isa_pkg::SBC};
	assign b_in = subtract ? ~exe.operand : exe.operand;
	assign carry_in = (exe.cmd.alu_op == cpu_isa_pkg::CMP) ? 1'b1 : c;
	assign sum = {1'b0, src} + {1'b0, b_in} + {{`CPU_DATA_W{1'b0}}, carry_in};
	assign overflow = (src[MSB] == b_in[MSB]) && (sum[MSB] != src[MSB]); // Signed wrap

	always_comb begin
		case (exe.cmd.alu_op)
			cpu_isa_pkg::ORA: result = src | exe.operand;
			cpu_isa_pkg::AND: result = src & exe.operand;
			cpu_isa_pkg::EOR: result = src ^ exe.operand;
			cpu_isa_pkg::LDA: result = exe.operand;
			cpu_isa_pkg::PASS: result = src; // Transfers
			default: result = sum[MSB:0]; // ADC, CMP, SBC
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			acc <= '0;
			n <= 1'b0;
			z <= 1'b0;
			c <= 1'b0;
			v <= 1'b0;
		end else if (exe.exec_strobe && rdy) begin
			if (exe.cmd.write_acc)
				acc[exe.cmd.dst_acc] <= result;
			if (exe.cmd.set_nz) begin
				n <= result[MSB];
				z <= (result == '0);
			end
			if (exe.cmd.force_c)
				c <= exe.cmd.force_c_val;
			else if (exe.cmd.set_c)
				c <= sum[`CPU_DATA_W];
			if (exe.cmd.set_v)
				v <= overflow;
		end
	end

	assign exe.store_data = src; // STA source

	always_comb begin
		case (exe.cond)
			cpu_isa_pkg::PL: exe.cond_true = !n;
			cpu_isa_pkg::MI: exe.cond_true = n;
			cpu_isa_pkg::VC: exe.cond_true = !v;
			cpu_isa_pkg::VS: exe.cond_true = v;
			cpu_isa_pkg::CC: exe.cond_true = !c;
			cpu_isa_pkg::CS: exe.cond_true = c;
			cpu_isa_pkg::NE: exe.cond_true = !z;
			default: exe.cond_true = z; // EQ
		endcase
	end
endmodule

/* logic/cpu.sv */
/*
 * Reduced 65Org16-style core with accumulators A to D.
 * Single word bus: addr, we and data_out sampled on rdy-high cycles,
 * read data on data_in the following cycle. rdy low freezes the core.
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
	input  logic clk,
	input  logic reset,
	input  logic rdy,
	output logic [`CPU_ADDR_W-1:0] addr,
	output logic we,
	output logic [`CPU_DATA_W-1:0] data_out,
	input  logic [`CPU_DATA_W-1:0] data_in
);
	cpu_isa_pkg::instr_t ir; // Current instruction word
	cpu_isa_pkg::addr_mode_t mode;
	cpu_ctrl_pkg::exec_cmd_t cmd;

	exec_if exe_bus ();

	sequencer seq_i (
		.clk, .reset, .rdy,
		.addr, .we, .data_out, .data_in,
		.ir, .mode, .cmd,
		.exe(exe_bus)
	);

	instr_decoder dec_i (.ir, .mode, .cmd);

	execute_unit exe_i (.clk, .reset, .rdy, .exe(exe_bus));
endmodule

/* test/cpu_asserts.sv */
/*
 * Bus-protocol checks for cpu, bound into every cpu instance.
 * fail_count holds the number of failed assertions so far.
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_asserts (
	input logic clk,
	input logic reset,
	input logic rdy,
	input logic [`CPU_ADDR_W-1:0] addr,
	input logic we,
	input logic [`CPU_DATA_W-1:0] data_out
);
	int fail_count = 0;

	we_low_after_reset: assert property (@(posedge clk) ($past(reset) && !reset) |-> !we)
		else begin $error("we high in first cycle after reset"); fail_count++; end

	bus_stable_in_pause: assert property (@(posedge clk) disable iff (reset)
		($past(!rdy) && !$past(reset)) |->
		(addr == $past(addr) && we == $past(we) && data_out == $past(data_out)))
		else begin $error("bus changed while rdy low"); fail_count++; end

	single_write: assert property (@(posedge clk) disable iff (reset)
		($past(rdy && we) && !$past(reset)) |-> !(rdy && we))
		else begin $error("we high on two rdy-high cycles in a row"); fail_count++; end
endmodule

bind cpu cpu_asserts asserts_i (.clk, .reset, .rdy, .addr, .we, .data_out);

/* test/cpu_tb.sv */
/*
 * Directed tests for cpu with a word memory model on the single bus.
 * Each test loads a program at CPU_RESET_PC, runs to a store at 0000_FFFF
 * and compares every write against values worked out from the ISA rules.
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;
	localparam logic [31:0] MARK_ADDR = 32'h0000_FFFF; // End-of-program store
	logic clk;
	logic reset;
	logic rdy;
	logic we;
	logic [`CPU_ADDR_W-1:0] addr;
	logic [`CPU_DATA_W-1:0] data_out;
	logic [`CPU_DATA_W-1:0] data_in = '0;
	logic [15:0] prog [logic [31:0]]; // Program and preloaded data
	logic [15:0] wmem [logic [31:0]]; // Words written by the core
	logic [47:0] wq[$]; // {addr, data} per write
	logic [47:0] ref_q[$];
	logic [47:0] saved_q[$]; // Unpaused run of test 2
	logic [31:0] rd_addr = '0;
	logic [31:0] first_addr = '0;
	logic [31:0] prog_pc;
	logic [31:0] lcg_state = 32'd13;
	logic first_we = 1'b0;
	logic first_seen = 1'b0;
	logic marker_seen = 1'b0;
	logic [15:0] x_val;
	logic [15:0] y_val;
	logic [15:0] z_val;
	int instr_count;

	cpu dut_i (.clk, .reset, .rdy, .addr, .we, .data_out, .data_in);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function logic [15:0] read_mem(input logic [31:0] a);
		if (wmem.exists(a))
			return wmem[a];
		if (prog.exists(a))
			return prog[a];
		return a[31:16] ^ a[15:0] ^ 16'h5A5A; // Fill over the whole address
	endfunction

	// Memory side of the bus
	always @(posedge clk) begin
		if (reset) begin
			first_seen <= 1'b0;
			marker_seen <= 1'b0;
			wq.delete();
			wmem.delete();
		end else if (rdy) begin
			rd_addr <= addr; // Read data next cycle
			if (!first_seen) begin
				first_addr <= addr;
				first_we <= we;
				first_seen <= 1'b1;
			end
			if (we) begin
				wmem[addr] = data_out;
				wq.push_back({addr, data_out});
				if (addr == MARK_ADDR)
					marker_seen <= 1'b1;
			end
		end
	end

	always @(negedge clk)
		data_in <= read_mem(rd_addr);

	task check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	function logic [15:0] acc_word(input logic [1:0] src, input logic [1:0] dst,
		input logic [7:0] opc);
		return {4'b0000, src, dst, opc};
	endfunction

	task put(input logic [15:0] w);
		prog[prog_pc] = w;
		prog_pc = prog_pc + 32'd1;
	endtask

	task op1(input logic [15:0] w);
		put(w);
		instr_count++;
	endtask

	task op_imm(input logic [15:0] w, input logic [15:0] v);
		put(w);
		put(v);
		instr_count++;
	endtask

	task op_abs(input logic [15:0] w, input logic [31:0] a);
		put(w);
		put(a[15:0]); // Low word first
		put(a[31:16]);
		instr_count++;
	endtask

	task start_program();
		@(negedge clk);
		reset = 1'b1;
		rdy = 1'b1;
		prog.delete();
		ref_q.delete();
		prog_pc = `CPU_RESET_PC;
		instr_count = 0;
	endtask

	task end_program(); // Marker store of A, then JMP to itself
		op_abs(acc_word(2'd0, 2'd0, 8'h8D), MARK_ADDR);
		op_abs(16'h004C, prog_pc);
	endtask

	task run_to_marker(input bit paused);
		int cycles;
		int limit;
		int burst;
		cycles = 0;
		burst = 0;
		limit = instr_count * 6 * 4;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		while (!marker_seen) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: no marker store after %0d cycles", cycles);
				$display("CHECKS FAILED");
				$fatal(1);
			end
			if (paused) begin
				if (burst == 0) begin
					rdy = ~rdy; // Alternate high and low bursts
					burst = 1 + int'(lcg_next() % 16'd4);
				end
				burst--;
			end
		end
		rdy = 1'b1;
	endtask

	task compare_writes(input string tag);
		check({tag, " write count"}, 64'(wq.size()), 64'(ref_q.size()));
		foreach (ref_q[i])
			check($sformatf("%s write[%0d]", tag, i), 64'(wq[i]), 64'(ref_q[i]));
	endtask

	task reset_fetch_test();
		start_program();
		end_program();
		run_to_marker(1'b0);
		check("first addr", 64'(first_addr), 64'(`CPU_RESET_PC));
		check("first we", 64'(first_we), 64'd0);
		ref_q.push_back({MARK_ADDR, 16'h0000});
		compare_writes("reset");
	endtask

	task imm_arith_test(input bit paused);
		logic [15:0] s1;
		logic [15:0] s2;
		start_program();
		if (!paused) begin
			x_val = lcg_next();
			y_val = lcg_next();
			z_val = lcg_next();
		end
		op_imm(acc_word(2'd0, 2'd0, 8'hA9), x_val); // LDA #x
		op_imm(acc_word(2'd0, 2'd0, 8'h69), y_val); // ADC #y, C clear
		op_abs(acc_word(2'd0, 2'd0, 8'h8D), 32'h0000_1000);
		op1(16'h0038); // SEC
		op_imm(acc_word(2'd0, 2'd0, 8'hE9), z_val); // SBC #z
		op_abs(acc_word(2'd0, 2'd0, 8'h8D), 32'h0000_1001);
		end_program();
		run_to_marker(paused);
		s1 = x_val + y_val;
		s2 = s1 - z_val;
		ref_q.push_back({32'h0000_1000, s1});
		ref_q.push_back({32'h0000_1001, s2});
		ref_q.push_back({MARK_ADDR, s2});
		if (paused) begin
			ref_q = saved_q; // Pauses must not change the write trace
			compare_writes("paused");
		end else begin
			compare_writes("arith");
			saved_q = wq;
		end
	endtask

	task acc_field_test();
		logic [15:0] p;
		logic [15:0] q;
		logic [15:0] r;
		logic [15:0] r2;
		p = lcg_next();
		q = lcg_next();
		r = lcg_next();
		r2 = lcg_next();
		start_program();
		op_imm(acc_word(2'd0, 2'd0, 8'hA9), p); // A = p
		op_imm(acc_word(2'd0, 2'd1, 8'hA9), q); // B = q
		op1(acc_word(2'd0, 2'd2, 8'h8B)); // C = A
		op1(acc_word(2'd1, 2'd3, 8'h8B)); // D = B
		op_imm(acc_word(2'd2, 2'd0, 8'h09), r); // A = C | r
		op_imm(acc_word(2'd3, 2'd1, 8'h29), r); // B = D & r
		op_imm(acc_word(2'd1, 2'd3, 8'h49), r2); // D = B ^ r2
		op_abs(acc_word(2'd2, 2'd0, 8'h8D), 32'h0000_2000);
		op_abs(acc_word(2'd3, 2'd0, 8'h8D), 32'h0000_2001);
		op_abs(acc_word(2'd0, 2'd0, 8'h8D), 32'h0000_2002);
		op_abs(acc_word(2'd1, 2'd0, 8'h8D), 32'h0000_2003);
		end_program();
		run_to_marker(1'b0);
		ref_q.push_back({32'h0000_2000, p});
		ref_q.push_back({32'h0000_2001, (q & r) ^ r2});
		ref_q.push_back({32'h0000_2002, p | r});
		ref_q.push_back({32'h0000_2003, q & r});
		ref_q.push_back({MARK_ADDR, p | r});
		compare_writes("fields");
	endtask

	task mem_mode_test();
		logic [15:0] m1;
		logic [15:0] m2;
		m1 = lcg_next();
		m2 = lcg_next();
		start_program();
		prog[32'h0000_0040] = m1;
		prog[32'h0001_2345] = m2;
		op_imm(acc_word(2'd0, 2'd0, 8'hA5), 16'h0040); // LDA zp
		op_abs(acc_word(2'd0, 2'd0, 8'h6D), 32'h0001_2345); // ADC abs
		op_imm(acc_word(2'd0, 2'd0, 8'h85), 16'h0050); // STA zp
		end_program();
		run_to_marker(1'b0);
		ref_q.push_back({32'h0000_0050, m1 + m2});
		ref_q.push_back({MARK_ADDR, m1 + m2});
		compare_writes("memory");
	endtask

	task branch_test();
		logic [15:0] k;
		k = lcg_next();
		start_program();
		op_imm(acc_word(2'd0, 2'd0, 8'hA9), k);
		op_imm(acc_word(2'd0, 2'd0, 8'hC9), k); // Equal, Z set
		op_imm(16'h00F0, 16'd3); // BEQ over poison
		op_abs(acc_word(2'd0, 2'd0, 8'h8D), 32'h0000_3000);
		op_imm(acc_word(2'd0, 2'd0, 8'hC9), k + 16'd1); // Unequal
		op_imm(16'h00D0, 16'd3); // BNE
		op_abs(acc_word(2'd0, 2'd0, 8'h8D), 32'h0000_3001);
		op1(16'h0038);
		op_imm(16'h00B0, 16'd3); // BCS
		op_abs(acc_word(2'd0, 2'd0, 8'h8D), 32'h0000_3002);
		op_abs(16'h004C, prog_pc + 32'd6); // JMP past next store
		op_abs(acc_word(2'd0, 2'd0, 8'h8D), 32'h0000_3003);
		end_program();
		run_to_marker(1'b0);
		ref_q.push_back({MARK_ADDR, k}); // Only the marker, no poison
		compare_writes("branch");
	endtask

	initial begin
		reset = 1'b1;
		rdy = 1'b1;
		reset_fetch_test();
		imm_arith_test(1'b0);
		acc_field_test();
		mem_mode_test();
		branch_test();
		imm_arith_test(1'b1);
		if (dut_i.asserts_i.fail_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end
endmodule

/* all.f */
+incdir+logic
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/exec_if.sv
logic/instr_decoder.sv
logic/sequencer.sv
logic/execute_unit.sv
logic/cpu.sv
test/cpu_asserts.sv
test/cpu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = cpu_tb
FILELIST = all.f
LOG = sim.log

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
